// ==== verilog/ooo_config.svh ====
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// Architectural register file
`define NUM_GPR      8
`define GPR_IDX_SIZE 3
`define DATA_SIZE    32

// Reorder buffer depth, a power of two so the pointers wrap on their own
`define ROB_SIZE     8
`define ROB_IDX_SIZE 3

// Reservation station entries
`define RS_SIZE      4

`endif

// ==== verilog/ooo_pkg.sv ====
`include "ooo_config.svh"

package ooo_pkg;

  typedef enum logic [2:0] {
    FU_ADD   = 3'd0,
    FU_SUB   = 3'd1,
    FU_AND   = 3'd2,
    FU_ORR   = 3'd3,
    FU_MOVI  = 3'd4,
    FU_CMP   = 3'd5,
    FU_BCOND = 3'd6
  } fu_op_t;

  typedef enum logic [2:0] {
    COND_EQ = 3'd0,
    COND_NE = 3'd1,
    COND_LT = 3'd2,
    COND_GE = 3'd3,
    COND_AL = 3'd4
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  typedef struct packed {
    logic                     valid;
    logic [`GPR_IDX_SIZE-1:0] gpr_index;
    logic                     writes_gpr;
    logic                     set_nzcv;
    logic [`DATA_SIZE-1:0]    value;
    nzcv_t                    nzcv;
    logic                     is_branch;
    logic                     mispredict;
  } rob_entry_t;

endpackage

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`include "ooo_config.svh"

module reg_file (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  // Rename at issue
  input  logic                     issue_fire,
  input  logic [`GPR_IDX_SIZE-1:0] issue_dst,
  input  logic [`GPR_IDX_SIZE-1:0] issue_src1,
  input  logic [`GPR_IDX_SIZE-1:0] issue_src2,
  input  logic                     issue_writes_gpr,
  input  logic                     issue_set_nzcv,
  input  logic [`ROB_IDX_SIZE-1:0] alloc_index,
  // Retire from the ROB head
  input  logic                     commit_valid,
  input  logic [`GPR_IDX_SIZE-1:0] commit_gpr,
  input  logic                     commit_writes_gpr,
  input  logic                     commit_set_nzcv,
  input  logic [`DATA_SIZE-1:0]    commit_value,
  input  ooo_pkg::nzcv_t           commit_nzcv,
  input  logic [`ROB_IDX_SIZE-1:0] commit_index,
  input  logic                     redirect,
  // Operand lookup
  output logic                     src1_busy,
  output logic [`ROB_IDX_SIZE-1:0] src1_tag,
  output logic [`DATA_SIZE-1:0]    src1_value,
  output logic                     src2_busy,
  output logic [`ROB_IDX_SIZE-1:0] src2_tag,
  output logic [`DATA_SIZE-1:0]    src2_value,
  output logic                     nzcv_busy,
  output logic [`ROB_IDX_SIZE-1:0] nzcv_tag,
  output ooo_pkg::nzcv_t           nzcv_value
);

  logic [`DATA_SIZE-1:0]    gpr     [`NUM_GPR];
  logic [`ROB_IDX_SIZE-1:0] gpr_tag [`NUM_GPR];
  logic [`NUM_GPR-1:0]      gpr_busy;
  ooo_pkg::nzcv_t           flags;
  logic [`ROB_IDX_SIZE-1:0] flags_tag;
  logic                     flags_busy;

  assign src1_busy  = gpr_busy[issue_src1];
  assign src1_tag   = gpr_tag[issue_src1];
  assign src1_value = gpr[issue_src1];
  assign src2_busy  = gpr_busy[issue_src2];
  assign src2_tag   = gpr_tag[issue_src2];
  assign src2_value = gpr[issue_src2];
  assign nzcv_busy  = flags_busy;
  assign nzcv_tag   = flags_tag;
  assign nzcv_value = flags;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      gpr        <= '{default: '0};
      gpr_tag    <= '{default: '0};
      gpr_busy   <= '0;
      flags      <= '0;
      flags_tag  <= '0;
      flags_busy <= 1'b0;
    end else begin
      if (commit_valid && commit_writes_gpr) begin
        gpr[commit_gpr] <= commit_value;
        // A younger rename of the same register keeps it busy
        if (gpr_tag[commit_gpr] == commit_index) begin
          gpr_busy[commit_gpr] <= 1'b0;
        end
      end
      if (commit_valid && commit_set_nzcv) begin
        flags <= commit_nzcv;
        if (flags_tag == commit_index) begin
          flags_busy <= 1'b0;
        end
      end
      // Issue wins over a commit to the same register at this edge
      if (issue_fire && issue_writes_gpr) begin
        gpr_busy[issue_dst] <= 1'b1;
        gpr_tag[issue_dst]  <= alloc_index;
      end
      if (issue_fire && issue_set_nzcv) begin
        flags_busy <= 1'b1;
        flags_tag  <= alloc_index;
      end
      // Every in-flight producer was squashed
      if (redirect) begin
        gpr_busy   <= '0;
        flags_busy <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/100ps
`include "ooo_config.svh"

module reorder_buffer (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  // Allocation
  input  logic                     issue_fire,
  input  logic [`GPR_IDX_SIZE-1:0] issue_dst,
  input  logic                     issue_writes_gpr,
  input  logic                     issue_set_nzcv,
  input  logic                     issue_is_branch,
  // Operand forwarding by tag
  input  logic [`ROB_IDX_SIZE-1:0] look1_tag,
  input  logic [`ROB_IDX_SIZE-1:0] look2_tag,
  input  logic [`ROB_IDX_SIZE-1:0] lookf_tag,
  // Writeback from the ALU
  input  logic                     bc_valid,
  input  logic [`ROB_IDX_SIZE-1:0] bc_index,
  input  logic [`DATA_SIZE-1:0]    bc_value,
  input  ooo_pkg::nzcv_t           bc_nzcv,
  input  logic                     bc_taken,
  output logic                     look1_valid,
  output logic [`DATA_SIZE-1:0]    look1_value,
  output logic                     look2_valid,
  output logic [`DATA_SIZE-1:0]    look2_value,
  output logic                     lookf_valid,
  output ooo_pkg::nzcv_t           lookf_nzcv,
  output logic [`ROB_IDX_SIZE-1:0] alloc_index,
  output logic                     rob_full,
  // Commit port
  output logic                     commit_valid,
  output logic [`GPR_IDX_SIZE-1:0] commit_gpr,
  output logic                     commit_writes_gpr,
  output logic                     commit_set_nzcv,
  output logic [`DATA_SIZE-1:0]    commit_value,
  output ooo_pkg::nzcv_t           commit_nzcv,
  output logic [`ROB_IDX_SIZE-1:0] commit_index,
  output logic                     redirect,
  output logic [`DATA_SIZE-1:0]    redirect_pc
);

  ooo_pkg::rob_entry_t      rob [`ROB_SIZE];
  logic [`ROB_IDX_SIZE-1:0] commit_ptr;
  logic [`ROB_IDX_SIZE-1:0] next_ptr;
  logic [`ROB_IDX_SIZE:0]   count;
  ooo_pkg::rob_entry_t      head;
  logic                     flush;

  assign head        = rob[commit_ptr];
  assign alloc_index = next_ptr;
  assign rob_full    = (count == `ROB_SIZE);

  assign commit_valid      = (count != '0) && head.valid;
  assign commit_gpr        = head.gpr_index;
  assign commit_writes_gpr = head.writes_gpr;
  assign commit_set_nzcv   = head.set_nzcv;
  assign commit_value      = head.value;
  assign commit_nzcv       = head.nzcv;
  assign commit_index      = commit_ptr;

  // Taken branch at the head squashes every younger entry
  assign flush = commit_valid && head.is_branch && head.mispredict;

  assign look1_valid = rob[look1_tag].valid;
  assign look1_value = rob[look1_tag].value;
  assign look2_valid = rob[look2_tag].valid;
  assign look2_value = rob[look2_tag].value;
  assign lookf_valid = rob[lookf_tag].valid;
  assign lookf_nzcv  = rob[lookf_tag].nzcv;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      rob         <= '{default: '0};
      commit_ptr  <= '0;
      next_ptr    <= '0;
      count       <= '0;
      redirect    <= 1'b0;
      redirect_pc <= '0;
    end else if (flush) begin
      for (int i = 0; i < `ROB_SIZE; i++) begin
        rob[i].valid <= 1'b0;
      end
      commit_ptr  <= '0;
      next_ptr    <= '0;
      count       <= '0;
      redirect    <= 1'b1;
      // Branch target travels in the value field
      redirect_pc <= head.value;
    end else begin
      redirect <= 1'b0;
      // Results return out of order; late ones from squashed work are dropped
      if (bc_valid && !redirect) begin
        rob[bc_index].valid      <= 1'b1;
        rob[bc_index].value      <= bc_value;
        rob[bc_index].nzcv       <= bc_nzcv;
        rob[bc_index].mispredict <= bc_taken;
      end
      if (issue_fire) begin
        rob[next_ptr].valid      <= 1'b0;
        rob[next_ptr].gpr_index  <= issue_dst;
        rob[next_ptr].writes_gpr <= issue_writes_gpr;
        rob[next_ptr].set_nzcv   <= issue_set_nzcv;
        rob[next_ptr].is_branch  <= issue_is_branch;
        rob[next_ptr].mispredict <= 1'b0;
        next_ptr <= next_ptr + 1'b1;
      end
      if (commit_valid) begin
        commit_ptr <= commit_ptr + 1'b1;
      end
      if (issue_fire && !commit_valid) begin
        count <= count + 1'b1;
      end else if (!issue_fire && commit_valid) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== verilog/reservation_station.sv ====
`timescale 1ns/100ps
`include "ooo_config.svh"

module reservation_station (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic                     issue_fire,
  input  ooo_pkg::fu_op_t          issue_op,
  input  ooo_pkg::cond_t           issue_cond,
  input  logic [`DATA_SIZE-1:0]    issue_imm,
  input  logic [`DATA_SIZE-1:0]    issue_target,
  input  logic [`ROB_IDX_SIZE-1:0] alloc_index,
  // Rename state from the register file
  input  logic                     src1_busy,
  input  logic [`ROB_IDX_SIZE-1:0] src1_tag,
  input  logic [`DATA_SIZE-1:0]    src1_value,
  input  logic                     src2_busy,
  input  logic [`ROB_IDX_SIZE-1:0] src2_tag,
  input  logic [`DATA_SIZE-1:0]    src2_value,
  input  logic                     nzcv_busy,
  input  logic [`ROB_IDX_SIZE-1:0] nzcv_tag,
  input  ooo_pkg::nzcv_t           nzcv_value,
  // Finished but not yet committed results
  input  logic                     look1_valid,
  input  logic [`DATA_SIZE-1:0]    look1_value,
  input  logic                     look2_valid,
  input  logic [`DATA_SIZE-1:0]    look2_value,
  input  logic                     lookf_valid,
  input  ooo_pkg::nzcv_t           lookf_nzcv,
  input  logic                     bc_valid,
  input  logic [`ROB_IDX_SIZE-1:0] bc_index,
  input  logic [`DATA_SIZE-1:0]    bc_value,
  input  ooo_pkg::nzcv_t           bc_nzcv,
  input  logic                     redirect,
  output logic                     rs_full,
  output logic                     disp_valid,
  output ooo_pkg::fu_op_t          disp_op,
  output ooo_pkg::cond_t           disp_cond,
  output logic [`DATA_SIZE-1:0]    disp_a,
  output logic [`DATA_SIZE-1:0]    disp_b,
  output ooo_pkg::nzcv_t           disp_nzcv,
  output logic [`DATA_SIZE-1:0]    disp_target,
  output logic [`ROB_IDX_SIZE-1:0] disp_index
);

  localparam int SEL_W = $clog2(`RS_SIZE);

  logic [`RS_SIZE-1:0]      valid;
  logic [`RS_SIZE-1:0]      a_rdy;
  logic [`RS_SIZE-1:0]      b_rdy;
  logic [`RS_SIZE-1:0]      f_rdy;
  // older[i][j] is set when entry i was issued before entry j
  logic [`RS_SIZE-1:0]      older  [`RS_SIZE];
  ooo_pkg::fu_op_t          op     [`RS_SIZE];
  ooo_pkg::cond_t           cond   [`RS_SIZE];
  logic [`ROB_IDX_SIZE-1:0] a_tag  [`RS_SIZE];
  logic [`ROB_IDX_SIZE-1:0] b_tag  [`RS_SIZE];
  logic [`ROB_IDX_SIZE-1:0] f_tag  [`RS_SIZE];
  logic [`ROB_IDX_SIZE-1:0] index  [`RS_SIZE];
  logic [`DATA_SIZE-1:0]    a_val  [`RS_SIZE];
  logic [`DATA_SIZE-1:0]    b_val  [`RS_SIZE];
  logic [`DATA_SIZE-1:0]    target [`RS_SIZE];
  ooo_pkg::nzcv_t           f_val  [`RS_SIZE];

  logic                     uses_regs;
  logic                     uses_flags;
  logic                     in_a_rdy;
  logic                     in_b_rdy;
  logic                     in_f_rdy;
  logic [`DATA_SIZE-1:0]    in_a_val;
  logic [`DATA_SIZE-1:0]    in_b_val;
  ooo_pkg::nzcv_t           in_f_val;
  logic [`RS_SIZE-1:0]      ready;
  logic [SEL_W-1:0]         free_slot;
  logic [SEL_W-1:0]         sel;
  logic                     any_ready;

  // Operand merge at issue, the same-cycle broadcast included
  always_comb begin
    uses_regs  = issue_op inside {ooo_pkg::FU_ADD, ooo_pkg::FU_SUB, ooo_pkg::FU_AND,
                                  ooo_pkg::FU_ORR, ooo_pkg::FU_CMP};
    uses_flags = issue_op inside {ooo_pkg::FU_CMP, ooo_pkg::FU_BCOND};
    in_a_rdy = !uses_regs || !src1_busy || look1_valid || (bc_valid && bc_index == src1_tag);
    in_b_rdy = !uses_regs || !src2_busy || look2_valid || (bc_valid && bc_index == src2_tag);
    in_f_rdy = !uses_flags || !nzcv_busy || lookf_valid || (bc_valid && bc_index == nzcv_tag);
    in_a_val = !src1_busy ? src1_value : (look1_valid ? look1_value : bc_value);
    in_b_val = !src2_busy ? src2_value : (look2_valid ? look2_value : bc_value);
    in_f_val = !nzcv_busy ? nzcv_value : (lookf_valid ? lookf_nzcv : bc_nzcv);
    if (issue_op == ooo_pkg::FU_MOVI) begin
      in_b_val = issue_imm;
    end
  end

  // Lowest free slot, and the oldest entry with all operands in hand
  always_comb begin
    logic blocked;
    free_slot = '0;
    for (int i = `RS_SIZE - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_slot = SEL_W'(i);
      end
    end
    ready     = valid & a_rdy & b_rdy & f_rdy;
    sel       = '0;
    any_ready = 1'b0;
    for (int i = 0; i < `RS_SIZE; i++) begin
      blocked = 1'b0;
      for (int j = 0; j < `RS_SIZE; j++) begin
        if (j != i && ready[j] && older[j][i]) begin
          blocked = 1'b1;
        end
      end
      if (ready[i] && !blocked) begin
        sel       = SEL_W'(i);
        any_ready = 1'b1;
      end
    end
  end

  assign rs_full     = &valid;
  assign disp_valid  = any_ready && !redirect;
  assign disp_op     = op[sel];
  assign disp_cond   = cond[sel];
  assign disp_a      = a_val[sel];
  assign disp_b      = b_val[sel];
  assign disp_nzcv   = f_val[sel];
  assign disp_target = target[sel];
  assign disp_index  = index[sel];

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      valid <= '0;
      a_rdy <= '0;
      b_rdy <= '0;
      f_rdy <= '0;
      older <= '{default: '0};
    end else if (redirect) begin
      valid <= '0;
    end else begin
      for (int i = 0; i < `RS_SIZE; i++) begin
        if (bc_valid && valid[i]) begin
          if (bc_index == a_tag[i]) a_rdy[i] <= 1'b1;
          if (bc_index == b_tag[i]) b_rdy[i] <= 1'b1;
          if (bc_index == f_tag[i]) f_rdy[i] <= 1'b1;
        end
      end
      if (disp_valid) begin
        valid[sel] <= 1'b0;
      end
      if (issue_fire) begin
        valid[free_slot] <= 1'b1;
        a_rdy[free_slot] <= in_a_rdy;
        b_rdy[free_slot] <= in_b_rdy;
        f_rdy[free_slot] <= in_f_rdy;
        // New entry is younger than everything already waiting
        for (int j = 0; j < `RS_SIZE; j++) begin
          older[j][free_slot] <= 1'b1;
          older[free_slot][j] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge in_clk) begin
    for (int i = 0; i < `RS_SIZE; i++) begin
      if (bc_valid && !a_rdy[i] && bc_index == a_tag[i]) a_val[i] <= bc_value;
      if (bc_valid && !b_rdy[i] && bc_index == b_tag[i]) b_val[i] <= bc_value;
      if (bc_valid && !f_rdy[i] && bc_index == f_tag[i]) f_val[i] <= bc_nzcv;
    end
    if (issue_fire) begin
      op[free_slot]     <= issue_op;
      cond[free_slot]   <= issue_cond;
      target[free_slot] <= issue_target;
      index[free_slot]  <= alloc_index;
      a_tag[free_slot]  <= src1_tag;
      b_tag[free_slot]  <= src2_tag;
      f_tag[free_slot]  <= nzcv_tag;
      a_val[free_slot]  <= in_a_val;
      b_val[free_slot]  <= in_b_val;
      f_val[free_slot]  <= in_f_val;
    end
  end

endmodule

// ==== verilog/alu_unit.sv ====
`timescale 1ns/100ps
`include "ooo_config.svh"

module alu_unit (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic                     disp_valid,
  input  ooo_pkg::fu_op_t          disp_op,
  input  ooo_pkg::cond_t           disp_cond,
  input  logic [`DATA_SIZE-1:0]    disp_a,
  input  logic [`DATA_SIZE-1:0]    disp_b,
  input  ooo_pkg::nzcv_t           disp_nzcv,
  input  logic [`DATA_SIZE-1:0]    disp_target,
  input  logic [`ROB_IDX_SIZE-1:0] disp_index,
  output logic                     bc_valid,
  output logic [`ROB_IDX_SIZE-1:0] bc_index,
  output logic [`DATA_SIZE-1:0]    bc_value,
  output ooo_pkg::nzcv_t           bc_nzcv,
  output logic                     bc_taken
);

  localparam int MSB = `DATA_SIZE - 1;

  logic [`DATA_SIZE:0]   sum;
  logic [`DATA_SIZE:0]   diff;
  logic [`DATA_SIZE-1:0] result;
  ooo_pkg::nzcv_t        flags;
  logic                  taken;

  always_comb begin
    sum    = {1'b0, disp_a} + {1'b0, disp_b};
    // Carry out here means no borrow
    diff   = {1'b0, disp_a} + {1'b0, ~disp_b} + 1'b1;
    result = '0;
    flags  = '0;
    taken  = 1'b0;
    case (disp_op)
      ooo_pkg::FU_ADD: begin
        result  = sum[MSB:0];
        flags.c = sum[`DATA_SIZE];
        flags.v = (disp_a[MSB] == disp_b[MSB]) && (result[MSB] != disp_a[MSB]);
      end
      ooo_pkg::FU_SUB, ooo_pkg::FU_CMP: begin
        result  = diff[MSB:0];
        flags.c = diff[`DATA_SIZE];
        flags.v = (disp_a[MSB] != disp_b[MSB]) && (result[MSB] != disp_a[MSB]);
      end
      ooo_pkg::FU_AND:  result = disp_a & disp_b;
      ooo_pkg::FU_ORR:  result = disp_a | disp_b;
      ooo_pkg::FU_MOVI: result = disp_b;
      ooo_pkg::FU_BCOND: begin
        result = disp_target;
        case (disp_cond)
          ooo_pkg::COND_EQ: taken = disp_nzcv.z;
          ooo_pkg::COND_NE: taken = !disp_nzcv.z;
          ooo_pkg::COND_LT: taken = disp_nzcv.n != disp_nzcv.v;
          ooo_pkg::COND_GE: taken = disp_nzcv.n == disp_nzcv.v;
          ooo_pkg::COND_AL: taken = 1'b1;
          default:          taken = 1'b0;
        endcase
      end
      default: result = '0;
    endcase
    // Branches pass the flags they were evaluated against
    if (disp_op == ooo_pkg::FU_BCOND) begin
      flags = disp_nzcv;
    end else begin
      flags.n = result[MSB];
      flags.z = (result == '0);
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      bc_valid <= 1'b0;
    end else begin
      bc_valid <= disp_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    bc_index <= disp_index;
    bc_value <= result;
    bc_nzcv  <= flags;
    bc_taken <= taken;
  end

endmodule

// ==== verilog/ooo_core.sv ====
`timescale 1ns/100ps
`include "ooo_config.svh"

module ooo_core (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  // Decoded instruction from the issuer
  input  logic                     issue,
  input  ooo_pkg::fu_op_t          issue_op,
  input  ooo_pkg::cond_t           issue_cond,
  input  logic [`GPR_IDX_SIZE-1:0] issue_dst,
  input  logic [`GPR_IDX_SIZE-1:0] issue_src1,
  input  logic [`GPR_IDX_SIZE-1:0] issue_src2,
  input  logic [`DATA_SIZE-1:0]    issue_imm,
  input  logic [`DATA_SIZE-1:0]    issue_target,
  output logic                     full,
  // In-order retirement
  output logic                     commit_valid,
  output logic [`GPR_IDX_SIZE-1:0] commit_gpr,
  output logic                     commit_writes_gpr,
  output logic                     commit_set_nzcv,
  output logic [`DATA_SIZE-1:0]    commit_value,
  output ooo_pkg::nzcv_t           commit_nzcv,
  output logic [`ROB_IDX_SIZE-1:0] commit_index,
  output logic                     redirect,
  output logic [`DATA_SIZE-1:0]    redirect_pc
);

  logic                     issue_fire;
  logic                     issue_writes_gpr;
  logic                     issue_set_nzcv;
  logic                     issue_is_branch;
  logic [`ROB_IDX_SIZE-1:0] alloc_index;
  logic                     rob_full;
  logic                     rs_full;

  // Operand lookup
  logic                     src1_busy;
  logic                     src2_busy;
  logic                     nzcv_busy;
  logic [`ROB_IDX_SIZE-1:0] src1_tag;
  logic [`ROB_IDX_SIZE-1:0] src2_tag;
  logic [`ROB_IDX_SIZE-1:0] nzcv_tag;
  logic [`DATA_SIZE-1:0]    src1_value;
  logic [`DATA_SIZE-1:0]    src2_value;
  ooo_pkg::nzcv_t           nzcv_value;
  logic                     look1_valid;
  logic                     look2_valid;
  logic                     lookf_valid;
  logic [`DATA_SIZE-1:0]    look1_value;
  logic [`DATA_SIZE-1:0]    look2_value;
  ooo_pkg::nzcv_t           lookf_nzcv;

  // Dispatch to the ALU
  logic                     disp_valid;
  ooo_pkg::fu_op_t          disp_op;
  ooo_pkg::cond_t           disp_cond;
  logic [`DATA_SIZE-1:0]    disp_a;
  logic [`DATA_SIZE-1:0]    disp_b;
  ooo_pkg::nzcv_t           disp_nzcv;
  logic [`DATA_SIZE-1:0]    disp_target;
  logic [`ROB_IDX_SIZE-1:0] disp_index;

  // Result broadcast
  logic                     bc_valid;
  logic [`ROB_IDX_SIZE-1:0] bc_index;
  logic [`DATA_SIZE-1:0]    bc_value;
  ooo_pkg::nzcv_t           bc_nzcv;
  logic                     bc_taken;

  assign full       = rob_full || rs_full;
  // Nothing is accepted in the cycle the flush lands
  assign issue_fire = issue && !full && !redirect;

  assign issue_writes_gpr = issue_op inside {ooo_pkg::FU_ADD, ooo_pkg::FU_SUB, ooo_pkg::FU_AND,
                                             ooo_pkg::FU_ORR, ooo_pkg::FU_MOVI};
  assign issue_set_nzcv   = (issue_op == ooo_pkg::FU_CMP);
  assign issue_is_branch  = (issue_op == ooo_pkg::FU_BCOND);

  reg_file u_reg_file (.*);

  reorder_buffer u_rob (
    .look1_tag (src1_tag),
    .look2_tag (src2_tag),
    .lookf_tag (nzcv_tag),
    .*
  );

  reservation_station u_rs (.*);

  alu_unit u_alu (.*);

endmodule

// ==== dv/ooo_core_tb.sv ====
`timescale 1ns/100ps
`include "ooo_config.svh"

module ooo_core_tb;

  localparam int NUM_INSTR   = 200;
  localparam int CYCLE_LIMIT = 2000;

  typedef struct packed {
    ooo_pkg::fu_op_t          op;
    ooo_pkg::cond_t           cond;
    logic [`GPR_IDX_SIZE-1:0] dst;
    logic [`GPR_IDX_SIZE-1:0] src1;
    logic [`GPR_IDX_SIZE-1:0] src2;
    logic [`DATA_SIZE-1:0]    imm;
    logic [`DATA_SIZE-1:0]    target;
  } instr_t;

  logic                     in_clk;
  logic                     in_rst_n;
  logic                     issue;
  ooo_pkg::fu_op_t          issue_op;
  ooo_pkg::cond_t           issue_cond;
  logic [`GPR_IDX_SIZE-1:0] issue_dst;
  logic [`GPR_IDX_SIZE-1:0] issue_src1;
  logic [`GPR_IDX_SIZE-1:0] issue_src2;
  logic [`DATA_SIZE-1:0]    issue_imm;
  logic [`DATA_SIZE-1:0]    issue_target;
  logic                     full;
  logic                     commit_valid;
  logic [`GPR_IDX_SIZE-1:0] commit_gpr;
  logic                     commit_writes_gpr;
  logic                     commit_set_nzcv;
  logic [`DATA_SIZE-1:0]    commit_value;
  ooo_pkg::nzcv_t           commit_nzcv;
  logic [`ROB_IDX_SIZE-1:0] commit_index;
  logic                     redirect;
  logic [`DATA_SIZE-1:0]    redirect_pc;

  // Golden model state, in program order
  instr_t                   prog_q[$];
  instr_t                   cur_instr;
  instr_t                   seen_instr;
  logic [`DATA_SIZE-1:0]    model_gpr [`NUM_GPR];
  ooo_pkg::nzcv_t           model_flags;
  logic                     seen_issue;
  logic                     seen_commit;
  logic                     issue_started;
  int                       outstanding;
  int                       cycles;

  // Expected view of the ROB head
  logic                     exp_valid;
  logic                     exp_writes;
  logic                     exp_cmp;
  logic [`GPR_IDX_SIZE-1:0] exp_gpr;
  logic [`DATA_SIZE-1:0]    exp_value;
  ooo_pkg::nzcv_t           exp_nzcv;
  logic [`ROB_IDX_SIZE-1:0] exp_index;
  logic                     exp_redirect;
  logic [`DATA_SIZE-1:0]    exp_pc;

  ooo_core DUT (.*);

  always #5 in_clk = ~in_clk;

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic value_mismatch(string name, logic [31:0] got, logic [31:0] want);
    $display("Fail at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
    abort_run();
  endtask

  function automatic logic [`DATA_SIZE-1:0] alu_result(instr_t ins, logic [31:0] a,
                                                      logic [31:0] b);
    case (ins.op)
      ooo_pkg::FU_ADD:  return a + b;
      ooo_pkg::FU_SUB:  return a - b;
      ooo_pkg::FU_AND:  return a & b;
      ooo_pkg::FU_ORR:  return a | b;
      ooo_pkg::FU_MOVI: return ins.imm;
      default:          return '0;
    endcase
  endfunction

  // Flags of a - b, overflow taken from the exact signed difference
  function automatic ooo_pkg::nzcv_t compare_flags(logic [31:0] a, logic [31:0] b);
    ooo_pkg::nzcv_t f;
    longint         sdiff;
    logic [31:0]    d;
    d     = a - b;
    sdiff = longint'($signed(a)) - longint'($signed(b));
    f.n   = d[31];
    f.z   = (d == 32'd0);
    f.c   = (a >= b);
    f.v   = (sdiff > longint'(32'h7fff_ffff)) || (sdiff < -longint'(32'h8000_0000));
    return f;
  endfunction

  function automatic logic cond_holds(ooo_pkg::cond_t c, ooo_pkg::nzcv_t f);
    case (c)
      ooo_pkg::COND_EQ: return f.z;
      ooo_pkg::COND_NE: return !f.z;
      ooo_pkg::COND_LT: return f.n ^ f.v;
      ooo_pkg::COND_GE: return !(f.n ^ f.v);
      default:          return 1'b1;
    endcase
  endfunction

  function automatic logic writes_reg(ooo_pkg::fu_op_t op);
    return op inside {ooo_pkg::FU_ADD, ooo_pkg::FU_SUB, ooo_pkg::FU_AND,
                      ooo_pkg::FU_ORR, ooo_pkg::FU_MOVI};
  endfunction

  function automatic instr_t random_instr();
    instr_t ins;
    ins.dst    = 3'($urandom_range(0, 7));
    ins.src1   = 3'($urandom_range(0, 7));
    ins.src2   = 3'($urandom_range(0, 7));
    // Small immediates make equal compares likely
    ins.imm    = ($urandom_range(0, 1) == 0) ? 32'($urandom_range(0, 3)) : $urandom();
    ins.target = $urandom();
    ins.cond   = ooo_pkg::COND_AL;
    if ($urandom_range(0, 11) == 0) begin
      ins.op   = ooo_pkg::FU_BCOND;
      ins.cond = ooo_pkg::cond_t'(3'($urandom_range(0, 4)));
    end else begin
      ins.op = ooo_pkg::fu_op_t'(3'($urandom_range(0, 5)));
    end
    return ins;
  endfunction

  task automatic predict_head();
    instr_t h;
    exp_valid = (prog_q.size() != 0);
    if (exp_valid) begin
      h          = prog_q[0];
      exp_writes = writes_reg(h.op);
      exp_cmp    = (h.op == ooo_pkg::FU_CMP);
      exp_gpr    = h.dst;
      exp_value  = alu_result(h, model_gpr[h.src1], model_gpr[h.src2]);
      exp_nzcv   = compare_flags(model_gpr[h.src1], model_gpr[h.src2]);
    end
  endtask

  task automatic drive_instr(instr_t ins);
    issue_op     = ins.op;
    issue_cond   = ins.cond;
    issue_dst    = ins.dst;
    issue_src1   = ins.src1;
    issue_src2   = ins.src2;
    issue_imm    = ins.imm;
    issue_target = ins.target;
  endtask

  // Handshake and commit strobe sampled mid-cycle, where they are stable
  always @(negedge in_clk) begin
    seen_issue  = issue && !full && !redirect;
    seen_commit = commit_valid;
    seen_instr  = cur_instr;
  end

  // Retire in program order at the edge the DUT commits
  always @(posedge in_clk) begin
    instr_t         retired;
    logic           flushing;
    logic [31:0]    result;
    ooo_pkg::nzcv_t flags;
    flushing = 1'b0;
    if (seen_commit && prog_q.size() != 0) begin
      retired   = prog_q.pop_front();
      exp_index = exp_index + 1'b1;
      result = alu_result(retired, model_gpr[retired.src1], model_gpr[retired.src2]);
      flags  = compare_flags(model_gpr[retired.src1], model_gpr[retired.src2]);
      if (writes_reg(retired.op)) begin
        model_gpr[retired.dst] = result;
      end
      if (retired.op == ooo_pkg::FU_CMP) begin
        model_flags = flags;
      end
      if (retired.op == ooo_pkg::FU_BCOND && cond_holds(retired.cond, model_flags)) begin
        flushing  = 1'b1;
        exp_pc    = retired.target;
        // Both ROB pointers restart from zero
        exp_index = '0;
        prog_q.delete();
      end
    end
    exp_redirect = flushing;
    // Taken at the flush edge, then dropped with the rest
    if (seen_issue && !flushing) begin
      prog_q.push_back(seen_instr);
    end
    outstanding = prog_q.size();
    predict_head();
  end

  always @(posedge in_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      stop_on_error($sformatf("Timeout: the run did not finish within %0d cycles",
                              CYCLE_LIMIT));
    end
  end

  quiet_after_reset: assert property (@(negedge in_clk)
    !issue_started |-> !commit_valid && !redirect && !full)
    else stop_on_error("commit_valid, redirect or full was high before the first issue");

  commit_in_order: assert property (@(negedge in_clk) commit_valid |-> exp_valid)
    else stop_on_error("The DUT committed with no instruction outstanding in program order");

  check_writes: assert property (@(negedge in_clk)
    commit_valid |-> commit_writes_gpr == exp_writes)
    else value_mismatch("commit_writes_gpr", 32'(commit_writes_gpr), 32'(exp_writes));

  check_sets_flags: assert property (@(negedge in_clk)
    commit_valid |-> commit_set_nzcv == exp_cmp)
    else value_mismatch("commit_set_nzcv", 32'(commit_set_nzcv), 32'(exp_cmp));

  check_gpr: assert property (@(negedge in_clk)
    commit_valid && exp_writes |-> commit_gpr == exp_gpr)
    else value_mismatch("commit_gpr", 32'(commit_gpr), 32'(exp_gpr));

  check_value: assert property (@(negedge in_clk)
    commit_valid && exp_writes |-> commit_value == exp_value)
    else value_mismatch("commit_value", commit_value, exp_value);

  check_nzcv: assert property (@(negedge in_clk)
    commit_valid && exp_cmp |-> commit_nzcv == exp_nzcv)
    else value_mismatch("commit_nzcv", 32'(commit_nzcv), 32'(exp_nzcv));

  check_index: assert property (@(negedge in_clk)
    commit_valid |-> commit_index == exp_index)
    else value_mismatch("commit_index", 32'(commit_index), 32'(exp_index));

  check_redirect: assert property (@(negedge in_clk) redirect == exp_redirect)
    else value_mismatch("redirect", 32'(redirect), 32'(exp_redirect));

  check_redirect_pc: assert property (@(negedge in_clk) redirect |-> redirect_pc == exp_pc)
    else value_mismatch("redirect_pc", redirect_pc, exp_pc);

  full_at_rob_size: assert property (@(negedge in_clk) outstanding == `ROB_SIZE |-> full)
    else value_mismatch("full", 32'(full), 32'd1);

  // Station entries are a subset of the outstanding ones outside a flush
  full_only_when_occupied: assert property (@(negedge in_clk)
    outstanding < `RS_SIZE && !redirect |-> !full)
    else value_mismatch("full", 32'(full), 32'd0);

  initial begin
    int gap;
    in_clk        = 1'b0;
    in_rst_n      = 1'b0;
    issue         = 1'b0;
    cur_instr     = '0;
    drive_instr(cur_instr);
    model_gpr     = '{default: '0};
    model_flags   = '0;
    seen_issue    = 1'b0;
    seen_commit   = 1'b0;
    issue_started = 1'b0;
    exp_valid     = 1'b0;
    exp_index     = '0;
    exp_redirect  = 1'b0;
    exp_pc        = '0;
    void'($urandom(59284));
    repeat (5) @(posedge in_clk);
    #1 in_rst_n = 1'b1;
    repeat (2) begin
      @(posedge in_clk);
      #1;
    end
    for (int n = 0; n < NUM_INSTR; n++) begin
      cur_instr = random_instr();
      // Occasional idle cycles let the window drain
      gap = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
      repeat (gap) begin
        @(posedge in_clk);
        #1;
      end
      drive_instr(cur_instr);
      issue         = 1'b1;
      issue_started = 1'b1;
      // Hold the instruction until the core takes it
      do begin
        @(posedge in_clk);
        #1;
      end while (!seen_issue);
      issue = 1'b0;
    end
    while (outstanding != 0) begin
      @(posedge in_clk);
    end
    repeat (3) @(posedge in_clk);
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/ooo_pkg.sv
verilog/reg_file.sv
verilog/reorder_buffer.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/ooo_core.sv
dv/ooo_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module ooo_core_tb -f build.f -o sim_ooo_core &&
  ./obj_dir/sim_ooo_core | tee /dev/stderr | grep -q "Everything OK" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
